// File: all.f
+incdir+logic
logic/slave_agent_pkg.sv
logic/command_translator.sv
logic/pending_queue.sv
logic/response_builder.sv
logic/slave_agent.sv
sim/slave_agent_assertions.sv
sim/tb_slave_agent.sv

// File: Bender.yml
package:
  name: slave_agent

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/slave_agent_pkg.sv
      - logic/command_translator.sv
      - logic/pending_queue.sv
      - logic/response_builder.sv
      - logic/slave_agent.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/slave_agent_assertions.sv
      - sim/tb_slave_agent.sv

// File: sim/tb_slave_agent.sv
/* testbench for the slave agent with a random-timing slave model, a reference model of
   the expected responses and an in-order response checker */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module tb_slave_agent
   import slave_agent_pkg::*;
();

   // one expected response packet with its fields in port order
   typedef struct packed {
      logic    write;
      status_t status;
      data_t   data;
      addr_t   addr;
      id_t     src_id;
      id_t     dest_id;
   } exp_rsp_t;

   localparam int timeout_cycles = 400;

   logic    clk, reset;
   logic    cmd_valid, cmd_read, cmd_write, cmd_posted, cmd_ready;
   addr_t   cmd_addr, slv_address, rsp_addr;
   byteen_t cmd_byteen, slv_byteenable;
   data_t   cmd_data, slv_writedata, slv_readdata, rsp_data;
   id_t     cmd_src_id, cmd_dest_id, rsp_src_id, rsp_dest_id;
   logic    slv_read, slv_write, slv_waitrequest, slv_readdatavalid;
   status_t slv_response, rsp_status;
   logic    rsp_ready, rsp_valid, rsp_write;

   // slave memory and the shadow copy that only the reference model touches
   data_t    mem [256];
   data_t    shadow [256];
   // read returns still owed by the slave model, oldest first
   data_t    rd_data_q [$];
   status_t  rd_status_q [$];
   int       rd_due_q [$];
   exp_rsp_t exp_q [$];
   integer   seed = 32'hb8919cf7;
   logic     wait_rand, ready_rand, next_wait, next_ready, hung;
   int       cycle, last_due, errors, checks, tests, base_errors;
   int       accesses, exp_accesses, rsp_count, exp_rsp_count;

   slave_agent slave_agent_i (.*);

   bind slave_agent slave_agent_assertions slave_agent_assertions_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // fill pattern mixes every bit of the word index into each byte lane
   function automatic data_t fill_word(input logic [7:0] idx);
      return {idx ^ 8'h5a, ~idx, idx + 8'h31, {idx[3:0], idx[7:4]}};
   endfunction

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   // returns 1 when the command expects a response and fills in that response
   function automatic logic predict_response(input logic wr, input logic posted,
         input addr_t addr, input byteen_t be, input data_t wdata, input id_t src,
         input id_t dest, output exp_rsp_t e);
      int b;
      logic synth;
      synth = (be == '0) || (wr && !posted);
      if (wr && be != '0) begin
         for (b = 0; b < `SA_BE_W; b++) begin
            if (be[b]) begin
               shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
      e.write   = wr;
      e.addr    = addr;
      // the answer goes back to whoever sent the command
      e.src_id  = dest;
      e.dest_id = src;
      e.status  = `SA_RESP_OKAY;
      e.data    = '0;
      if (!synth) begin
         e.status = (addr >= 16'hf000) ? `SA_RESP_SLVERR : `SA_RESP_OKAY;
         e.data   = shadow[addr[9:2]];
      end
      return !(wr && posted);
   endfunction

   task automatic report_mismatch(input string msg);
      errors++;
      $display("mismatch at %0t ns: %s", $time, msg);
   endtask

   // ----------------------------------------
   // slave memory model
   // ----------------------------------------
   // accesses are taken at the falling edge before the edge that accepts them
   always @(negedge clk) begin : slave_model
      logic [31:0] r;
      int b;
      int due;
      r = $random(seed);
      next_wait  = wait_rand & r[4];
      next_ready = ~ready_rand | r[9];
      if (!reset && (slv_read || slv_write) && !slv_waitrequest) begin
         accesses++;
         checks++;
         if (slv_address[1:0] != 2'b00) begin
            report_mismatch($sformatf("slave access at %h is not word aligned", slv_address));
         end
         if (slv_write) begin
            for (b = 0; b < `SA_BE_W; b++) begin
               if (slv_byteenable[b]) begin
                  mem[slv_address[9:2]][8*b +: 8] = slv_writedata[8*b +: 8];
               end
            end
         end else begin
            rd_data_q.push_back(mem[slv_address[9:2]]);
            rd_status_q.push_back((slv_address >= 16'hf000) ? `SA_RESP_SLVERR : `SA_RESP_OKAY);
            // data comes back 1 to 4 cycles later and never overtakes an older read
            due = cycle + 2 + int'(r[1:0]);
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            rd_due_q.push_back(due);
         end
      end
   end

   // slave outputs and rsp_ready change 1 ns after the rising edge
   always @(posedge clk) begin : slave_drive
      cycle++;
      #1;
      slv_waitrequest = next_wait;
      rsp_ready       = next_ready;
      slv_readdatavalid = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
         slv_readdatavalid = 1'b1;
         slv_readdata      = rd_data_q.pop_front();
         slv_response      = rd_status_q.pop_front();
         void'(rd_due_q.pop_front());
      end
   end

   // ----------------------------------------
   // response checker
   // ----------------------------------------
   always @(negedge clk) begin : response_check
      exp_rsp_t e;
      if (!reset && rsp_valid && rsp_ready) begin
         rsp_count++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("a response arrived at %0t ns with no command waiting for one", $time);
         end else begin
            e = exp_q.pop_front();
            checks++;
            if ({rsp_write, rsp_status, rsp_data, rsp_addr, rsp_src_id, rsp_dest_id} !== e) begin
               report_mismatch({$sformatf("response %0d got w%0b st%0d %h @%h ids %0d/%0d",
                  rsp_count, rsp_write, rsp_status, rsp_data, rsp_addr, rsp_src_id,
                  rsp_dest_id), $sformatf(", expected w%0b st%0d %h @%h ids %0d/%0d",
                  e.write, e.status, e.data, e.addr, e.src_id, e.dest_id)});
            end
         end
      end
   end

   // ----------------------------------------
   // stimulus tasks
   // ----------------------------------------
   // called 1 ns after a rising edge and returns 1 ns after the accepting edge
   task automatic send_command(input logic wr, input logic posted, input addr_t addr,
         input byteen_t be, input data_t wdata, input id_t src, input id_t dest);
      exp_rsp_t e;
      int waited;
      if (hung) begin
         return;
      end
      cmd_valid   = 1'b1;
      cmd_read    = ~wr;
      cmd_write   = wr;
      cmd_posted  = posted;
      cmd_addr    = addr;
      cmd_byteen  = be;
      cmd_data    = wdata;
      cmd_src_id  = src;
      cmd_dest_id = dest;
      waited = 0;
      @(negedge clk);
      while (!cmd_ready && waited < timeout_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (!cmd_ready) begin
         hung = 1'b1;
         $display("timeout: cmd_ready stayed low for %0d cycles", timeout_cycles);
      end else begin
         if (predict_response(wr, posted, addr, be, wdata, src, dest, e)) begin
            exp_q.push_back(e);
            exp_rsp_count++;
         end
         if (be != '0) begin
            exp_accesses++;
         end
      end
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      cmd_valid = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic begin_test();
      base_errors = errors;
      @(posedge clk);
      #1;
   endtask

   // drains the responses and checks the totals so far
   task automatic end_test(input string name);
      int waited;
      cmd_valid = 1'b0;
      waited = 0;
      while (!hung && rsp_count < exp_rsp_count && waited < timeout_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (!hung && rsp_count < exp_rsp_count) begin
         hung = 1'b1;
         $display("timeout: only %0d of %0d responses arrived", rsp_count, exp_rsp_count);
      end
      checks += 2;
      if (accesses != exp_accesses) begin
         report_mismatch($sformatf("%0d slave accesses, expected %0d", accesses, exp_accesses));
      end
      if (rsp_count != exp_rsp_count) begin
         report_mismatch($sformatf("%0d responses, expected %0d", rsp_count, exp_rsp_count));
      end
      tests++;
      $display("test %s finished with %0d errors", name, errors - base_errors);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      logic [31:0] r;
      int i;
      {cmd_valid, cmd_read, cmd_write, cmd_posted} = 4'b0000;
      {cmd_addr, cmd_byteen, cmd_data, cmd_src_id, cmd_dest_id} = '0;
      {slv_waitrequest, slv_readdata, slv_readdatavalid, slv_response} = '0;
      {reset, rsp_ready, next_ready} = 3'b111;
      {wait_rand, ready_rand, next_wait, hung} = 4'b0000;
      {cycle, last_due, errors, checks, tests, base_errors} = '0;
      {accesses, exp_accesses, rsp_count, exp_rsp_count} = '0;
      for (i = 0; i < 256; i++) begin
         mem[i]    = fill_word(8'(i));
         shadow[i] = fill_word(8'(i));
      end
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;

      // idle state after the first edge out of reset with the slave ready
      base_errors = errors;
      @(posedge clk);
      @(negedge clk);
      checks++;
      if (slv_read !== 1'b0 || slv_write !== 1'b0 || rsp_valid !== 1'b0 || cmd_ready !== 1'b1) begin
         report_mismatch("ports are not idle with cmd_ready high after reset");
      end
      tests++;
      $display("test reset_state finished with %0d errors", errors - base_errors);

      wait_rand = 1'b1;
      begin_test();
      send_command(1'b0, 1'b0, 16'h0010, 4'hf, 32'h0, 3'd1, 3'd5);
      send_command(1'b0, 1'b0, 16'h0027, 4'h2, 32'h0, 3'd2, 3'd6);
      send_command(1'b0, 1'b0, 16'h03fc, 4'hf, 32'h0, 3'd3, 3'd4);
      send_command(1'b0, 1'b0, 16'hf004, 4'hf, 32'h0, 3'd7, 3'd0);
      send_command(1'b0, 1'b0, 16'hfffe, 4'hc, 32'h0, 3'd0, 3'd7);
      end_test("reads");

      begin_test();
      send_command(1'b1, 1'b1, 16'h0040, 4'hf, 32'h11223344, 3'd1, 3'd2);
      send_command(1'b1, 1'b0, 16'h0041, 4'h6, 32'haabbccdd, 3'd2, 3'd3);
      send_command(1'b1, 1'b1, 16'h0043, 4'h8, 32'h99000000, 3'd3, 3'd4);
      send_command(1'b0, 1'b0, 16'h0040, 4'hf, 32'h0, 3'd4, 3'd5);
      send_command(1'b1, 1'b0, 16'h0080, 4'h1, 32'h000000ee, 3'd5, 3'd6);
      send_command(1'b0, 1'b0, 16'h0082, 4'hf, 32'h0, 3'd6, 3'd1);
      end_test("writes");

      // zero byte enables reach neither the slave nor the memory
      begin_test();
      send_command(1'b0, 1'b0, 16'h0100, 4'h0, 32'h0, 3'd1, 3'd3);
      send_command(1'b1, 1'b0, 16'h0104, 4'h0, 32'hdeadbeef, 3'd2, 3'd4);
      send_command(1'b1, 1'b1, 16'h0108, 4'h0, 32'hcafef00d, 3'd3, 3'd5);
      send_command(1'b0, 1'b0, 16'h0104, 4'hf, 32'h0, 3'd4, 3'd6);
      end_test("zero_byte_enables");

      ready_rand = 1'b1;
      begin_test();
      for (i = 0; i < 80; i++) begin
         r = $random(seed);
         send_command(r[0], r[1], r[31:16], r[7:4], $random(seed), r[10:8], r[13:11]);
         if (r[3:2] == 2'b00) begin
            idle_cycles(int'(r[15:14]) + 1);
         end
      end
      end_test("random_traffic");

      errors = errors + slave_agent_i.slave_agent_assertions_i.fail_count;
      $display("tests %0d, checks %0d, responses %0d, slave accesses %0d, errors %0d",
         tests, checks, rsp_count, accesses, errors);
      if (errors == 0 && !hung) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/slave_agent_assertions.sv
/* concurrent checks on the slave agent ports and its pending queue state,
   attached to the top level with bind from the testbench */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module slave_agent_assertions
   import slave_agent_pkg::*;
(
   input logic    clk,
   input logic    reset,
   input logic    slv_read,
   input logic    slv_write,
   input logic    slv_readdatavalid,
   input logic    rsp_ready,
   input logic    rsp_valid,
   input logic    rsp_write,
   input status_t rsp_status,
   input data_t   rsp_data,
   input addr_t   rsp_addr,
   input id_t     rsp_src_id,
   input id_t     rsp_dest_id,
   input logic    pend_not_empty
);

   // number of assertion failures so far
   int fail_count = 0;

   // nothing reaches the slave or the response port while reset is high
   assert property (@(posedge clk) reset |-> !slv_read && !slv_write && !rsp_valid)
      else begin
         fail_count++;
         $error("a strobe or rsp_valid is high during reset");
      end

   // a stalled response keeps its valid and every field
   assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid
         && $stable({rsp_write, rsp_status, rsp_data, rsp_addr, rsp_src_id, rsp_dest_id}))
      else begin
         fail_count++;
         $error("response changed while rsp_ready was low");
      end

   // returned read data always finds its read record still waiting in the pending queue
   assert property (@(posedge clk) disable iff (reset) slv_readdatavalid |-> pend_not_empty)
      else begin
         fail_count++;
         $error("read data returned while no pending record was queued");
      end

endmodule

`default_nettype wire

// File: logic/slave_agent.sv
/* top level of the memory-mapped slave agent: command translator, pending record queue,
   read data queue and response builder wired between the three ports */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module slave_agent
   import slave_agent_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   // command stream
   input  logic    cmd_valid,
   input  logic    cmd_read,
   input  logic    cmd_write,
   input  logic    cmd_posted,
   input  addr_t   cmd_addr,
   input  byteen_t cmd_byteen,
   input  data_t   cmd_data,
   input  id_t     cmd_src_id,
   input  id_t     cmd_dest_id,
   output logic    cmd_ready,
   // slave port
   output addr_t   slv_address,
   output byteen_t slv_byteenable,
   output logic    slv_read,
   output logic    slv_write,
   output data_t   slv_writedata,
   input  logic    slv_waitrequest,
   input  data_t   slv_readdata,
   input  logic    slv_readdatavalid,
   input  status_t slv_response,
   // response stream
   input  logic    rsp_ready,
   output logic    rsp_valid,
   output logic    rsp_write,
   output status_t rsp_status,
   output data_t   rsp_data,
   output addr_t   rsp_addr,
   output id_t     rsp_src_id,
   output id_t     rsp_dest_id
);

   logic       pend_push;
   pend_rec_t  pend_rec;
   pend_rec_t  pend_head;
   logic       pend_not_empty;
   logic       pend_not_full;
   logic       pend_pop;
   rdata_rec_t rdata_head;
   logic       rdata_not_empty;
   logic       rdata_pop;

   // ----------------------------------------
   // producer side
   // ----------------------------------------
   command_translator command_translator_i (
      .clk, .reset,
      .cmd_valid, .cmd_read, .cmd_write, .cmd_posted, .cmd_addr, .cmd_byteen,
      .cmd_data, .cmd_src_id, .cmd_dest_id, .cmd_ready,
      .slv_address, .slv_byteenable, .slv_read, .slv_write, .slv_writedata,
      .slv_waitrequest,
      .pend_push, .pend_rec, .pend_not_full
   );

   pending_queue #(.width(`SA_PEND_W)) pending_queue_i (
      .clk, .reset,
      .push(pend_push), .push_data(pend_rec), .pop(pend_pop),
      .head(pend_head), .not_empty(pend_not_empty), .not_full(pend_not_full)
   );

   // never holds more entries than there are pending read records, so its
   // full flag is not needed
   pending_queue #(.width(`SA_RDATA_W)) rdata_queue_i (
      .clk, .reset,
      .push(slv_readdatavalid), .push_data({slv_response, slv_readdata}), .pop(rdata_pop),
      .head(rdata_head), .not_empty(rdata_not_empty), .not_full()
   );

   // ----------------------------------------
   // consumer side
   // ----------------------------------------
   response_builder response_builder_i (
      .pend_head, .pend_not_empty, .pend_pop,
      .rdata_head, .rdata_not_empty, .rdata_pop,
      .rsp_ready, .rsp_valid, .rsp_write, .rsp_status, .rsp_data, .rsp_addr,
      .rsp_src_id, .rsp_dest_id
   );

endmodule

`default_nettype wire

// File: logic/response_builder.sv
/* joins the oldest pending record with the oldest returned read data and presents one
   response packet per record, in command order */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module response_builder
   import slave_agent_pkg::*;
(
   // pending record queue
   input  pend_rec_t  pend_head,
   input  logic       pend_not_empty,
   output logic       pend_pop,
   // read data queue
   input  rdata_rec_t rdata_head,
   input  logic       rdata_not_empty,
   output logic       rdata_pop,
   // response stream
   input  logic       rsp_ready,
   output logic       rsp_valid,
   output logic       rsp_write,
   output status_t    rsp_status,
   output data_t      rsp_data,
   output addr_t      rsp_addr,
   output id_t        rsp_src_id,
   output id_t        rsp_dest_id
);

   logic    rec_synth;
   logic    rec_write;
   id_t     rec_src_id;
   id_t     rec_dest_id;
   addr_t   rec_addr;
   status_t rd_status;
   data_t   rd_data;
   logic    rsp_xfer;

   // ----------------------------------------
   // unpack queue heads
   // ----------------------------------------
   // byte enables ride along in the record but are not returned
   assign rec_synth   = pend_head[`SA_PEND_SYNTH_BIT];
   assign rec_write   = pend_head[`SA_PEND_WRITE_BIT];
   assign rec_src_id  = pend_head[`SA_PEND_SRC_LSB +: `SA_ID_W];
   assign rec_dest_id = pend_head[`SA_PEND_DEST_LSB +: `SA_ID_W];
   assign rec_addr    = pend_head[`SA_PEND_ADDR_LSB +: `SA_ADDR_W];

   assign rd_status = rdata_head[`SA_RDATA_W-1 -: `SA_STATUS_W];
   assign rd_data   = rdata_head[`SA_DATA_W-1:0];

   // ----------------------------------------
   // handshake
   // ----------------------------------------
   // a synthesized record is answered at once, a real read waits for its data;
   // the heads only move on a transfer, so the packet holds while rsp_ready is low
   assign rsp_valid = pend_not_empty & (rec_synth | rdata_not_empty);
   assign rsp_xfer  = rsp_valid & rsp_ready;

   // the record always leaves, read data only when the slave supplied it
   assign pend_pop  = rsp_xfer;
   assign rdata_pop = rsp_xfer & ~rec_synth;

   // ----------------------------------------
   // response fields
   // ----------------------------------------
   // IDs swap so the packet routes back to the requester
   assign rsp_src_id  = rec_dest_id;
   assign rsp_dest_id = rec_src_id;
   assign rsp_addr    = rec_addr;
   assign rsp_write   = rec_write;

   // suppressed commands and non-posted writes report OKAY with zero data
   always_comb begin
      if (rec_synth) begin
         rsp_status = `SA_RESP_OKAY;
         rsp_data   = '0;
      end else begin
         rsp_status = rd_status;
         rsp_data   = rd_data;
      end
   end

endmodule

`default_nettype wire

// File: logic/pending_queue.sv
/* synchronous FIFO of SA_QUEUE_DEPTH entries with full and empty flags, holding either
   pending records or returned read data depending on its width */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module pending_queue #(
   parameter int width = `SA_PEND_W
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  logic [width-1:0] push_data,
   input  logic             pop,
   output logic [width-1:0] head,
   output logic             not_empty,
   output logic             not_full
);

   localparam int depth = `SA_QUEUE_DEPTH;
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   logic [width-1:0] mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   // pointer step with explicit wrap, so depth need not be a power of two
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // a push into a full queue or a pop from an empty one is dropped here
   assign do_push = push & not_full;
   assign do_pop  = pop & not_empty;

   assign not_empty = (count != '0);
   assign not_full  = (count != cnt_w'(depth));

   // head shows the oldest entry, a push becomes visible one cycle later
   assign head = mem[rd_ptr];

   // ----------------------------------------
   // storage
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // ----------------------------------------
   // pointers and occupancy
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // simultaneous push and pop leave the count unchanged
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/command_translator.sv
/* turns single-beat command packets into slave read or write strobes and queues a
   pending record for every command that expects a response */
`timescale 1ns/1ps
`default_nettype none

`include "slave_agent_defines.svh"

module command_translator
   import slave_agent_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   // command stream
   input  logic    cmd_valid,
   input  logic    cmd_read,
   input  logic    cmd_write,
   input  logic    cmd_posted,
   input  addr_t   cmd_addr,
   input  byteen_t cmd_byteen,
   input  data_t   cmd_data,
   input  id_t     cmd_src_id,
   input  id_t     cmd_dest_id,
   output logic    cmd_ready,
   // slave port
   output addr_t   slv_address,
   output byteen_t slv_byteenable,
   output logic    slv_read,
   output logic    slv_write,
   output data_t   slv_writedata,
   input  logic    slv_waitrequest,
   // pending queue
   output logic      pend_push,
   output pend_rec_t pend_rec,
   input  logic      pend_not_full
);

   logic issue_en_q;
   logic suppress;
   logic nonposted_write;
   logic needs_rsp;
   logic synth;
   logic can_issue;

   // ----------------------------------------
   // issue enable
   // ----------------------------------------
   // strobes and cmd_ready stay off until the first edge after reset so that
   // nothing reaches the slave while reset is still releasing
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         issue_en_q <= 1'b0;
      end else begin
         issue_en_q <= 1'b1;
      end
   end

   // ----------------------------------------
   // command decode
   // ----------------------------------------
   // a command with no byte lanes enabled never touches the slave
   assign suppress        = ~|cmd_byteen;
   assign nonposted_write = cmd_write & ~cmd_posted;

   // reads and non-posted writes get an answer, posted writes do not
   assign needs_rsp = cmd_read | nonposted_write;

   // the builder makes up the answer for these, the slave never returns one
   assign synth = suppress | nonposted_write;

   // every command is held while the queue is full, even a posted write,
   // which keeps the ready path independent of the command type
   assign can_issue = issue_en_q & pend_not_full;

   // the slave decides acceptance unless the access is dropped anyway
   assign cmd_ready = can_issue & (~slv_waitrequest | suppress);

   // ----------------------------------------
   // slave port
   // ----------------------------------------
   // word aligned address, the byte offset is carried by the byte enables
   assign slv_address    = {cmd_addr[`SA_ADDR_W-1:`SA_MASK_BITS], {`SA_MASK_BITS{1'b0}}};
   assign slv_byteenable = cmd_byteen;
   assign slv_writedata  = cmd_data;

   // strobes are gated like cmd_ready so that command and slave acceptance
   // fall on the same edge
   assign slv_read  = cmd_valid & can_issue & cmd_read & ~suppress;
   assign slv_write = cmd_valid & can_issue & cmd_write & ~suppress;

   // ----------------------------------------
   // pending record
   // ----------------------------------------
   // the record keeps the unmasked address so the response echoes it as sent
   assign pend_push = cmd_valid & cmd_ready & needs_rsp;
   assign pend_rec  = {synth, cmd_write, cmd_src_id, cmd_dest_id, cmd_addr, cmd_byteen};

endmodule

`default_nettype wire

// File: logic/slave_agent_pkg.sv
/* vector types shared by the slave agent modules, imported by wildcard in each module
   header that needs one of them */
`default_nettype none

`include "slave_agent_defines.svh"

package slave_agent_pkg;

   // ----------------------------------------
   // command and slave port fields
   // ----------------------------------------
   // byte address as seen on the command stream
   typedef logic [`SA_ADDR_W-1:0] addr_t;

   // one full data word on the slave port
   typedef logic [`SA_DATA_W-1:0] data_t;

   // one enable bit per byte lane of data_t
   typedef logic [`SA_BE_W-1:0] byteen_t;

   // source or destination endpoint ID
   typedef logic [`SA_ID_W-1:0] id_t;

   // status codes are SA_RESP_OKAY and SA_RESP_SLVERR
   typedef logic [`SA_STATUS_W-1:0] status_t;

   // ----------------------------------------
   // queue entries
   // ----------------------------------------
   // one record per command that expects a response
   typedef logic [`SA_PEND_W-1:0] pend_rec_t;

   // one entry per read data beat returned by the slave
   typedef logic [`SA_RDATA_W-1:0] rdata_rec_t;

endpackage

`default_nettype wire

// File: logic/slave_agent_defines.svh
/* widths, queue depth, status codes and pending record layout for the slave agent,
   included by the package and by every module that sizes a port from these values */
`ifndef SLAVE_AGENT_DEFINES_SVH
`define SLAVE_AGENT_DEFINES_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define SA_ADDR_W 16
`define SA_DATA_W 32
`define SA_BE_W 4
`define SA_ID_W 3
// byte offset bits inside one data word, cleared on the way to the slave
`define SA_MASK_BITS 2
`define SA_QUEUE_DEPTH 4

// response status codes as the slave returns them
`define SA_STATUS_W 2
`define SA_RESP_OKAY 2'd0
`define SA_RESP_SLVERR 2'd2

// pending record is {synth, write, src_id, dest_id, addr, byteen}, synth on top
`define SA_PEND_W (2 + 2 * `SA_ID_W + `SA_ADDR_W + `SA_BE_W)
`define SA_PEND_SYNTH_BIT (`SA_PEND_W - 1)
`define SA_PEND_WRITE_BIT (`SA_PEND_W - 2)
`define SA_PEND_SRC_LSB (`SA_PEND_W - 2 - `SA_ID_W)
`define SA_PEND_DEST_LSB (`SA_PEND_SRC_LSB - `SA_ID_W)
`define SA_PEND_ADDR_LSB `SA_BE_W

// read-data entry keeps the status above the data word
`define SA_RDATA_W (`SA_STATUS_W + `SA_DATA_W)
`endif
